//--- common/wb_bram_consts.svh
`ifndef WB_BRAM_CONSTS_SVH
`define WB_BRAM_CONSTS_SVH

// Bus and RAM widths
`define WB_DATA_W       32
`define WB_SEL_W        4   // One select per byte lane
`define WB_ADDR_W       10  // Word address, not byte address

// RAM size in words
`define WB_RAM_DEPTH    (1 << `WB_ADDR_W)

// Cycle type identifier codes
`define WB_CTI_W        3
`define WB_CTI_CLASSIC  3'b000
`define WB_CTI_INCR     3'b010
`define WB_CTI_REG_ACK  3'b100  // Reserved code, master registers ack
`define WB_CTI_END      3'b111  // Last beat of a burst

`endif

//--- common/wb_bram_pkg.sv
package wb_bram_pkg;

    `include "wb_bram_consts.svh"

    // Master to slave
    typedef struct packed {
        logic [`WB_DATA_W-1:0] dat;  // Write data
        logic [`WB_SEL_W-1:0]  sel;  // Byte lane selects
        logic [`WB_ADDR_W-1:0] addr; // Word address
        logic [`WB_CTI_W-1:0]  cti;  // Cycle type
        logic                  stb;
        logic                  cyc;
        logic                  we;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic [`WB_DATA_W-1:0] dat; // Read data
        logic                  ack;
    } wb_rsp_t;

    // Controller to RAM
    typedef struct packed {
        logic [`WB_DATA_W-1:0] d;
        logic [`WB_ADDR_W-1:0] addr;
        logic                  we;
    } bram_port_t;

    // One word, seen whole or lane by lane
    typedef union packed {
        logic [`WB_DATA_W-1:0]           word;
        logic [`WB_SEL_W-1:0][7:0]       bytes; // bytes[0] is the low lane
    } bram_word_u;

endpackage

//--- design/bram_sp.sv
`timescale 1ns/1ps
`include "wb_bram_consts.svh"

module bram_sp (
    input  logic                    clk,
    input  wb_bram_pkg::bram_port_t ram_i,
    output logic [`WB_DATA_W-1:0]   q_o
);

    logic [`WB_DATA_W-1:0] mem [0:`WB_RAM_DEPTH-1]; // Word array

    // One port, registered read
    always_ff @(posedge clk)
    begin
        if (ram_i.we)
            mem[ram_i.addr] <= ram_i.d;
        q_o <= mem[ram_i.addr]; // Old contents on a write cycle
    end

endmodule

//--- design/wb_bram_top.sv
`timescale 1ns/1ps
`include "wb_bram_consts.svh"

module wb_bram_top #(
    parameter bit BURST_EN = 1'b1
) (
    input  logic                 clk,
    input  logic                 reset,
    input  wb_bram_pkg::wb_req_t wb_req_i,
    output wb_bram_pkg::wb_rsp_t wb_rsp_o
);
    import wb_bram_pkg::*;

    bram_port_t            ram_port; // Controller to RAM
    logic [`WB_DATA_W-1:0] ram_q;    // RAM read data

    wb_bram_ctrl #(
        .BURST_EN (BURST_EN)
    ) u_ctrl (
        .clk      (clk),
        .reset    (reset),
        .wb_req_i (wb_req_i),
        .wb_rsp_o (wb_rsp_o),
        .ram_o    (ram_port),
        .ram_q_i  (ram_q)
    );

    bram_sp u_ram (
        .clk   (clk),
        .ram_i (ram_port),
        .q_o   (ram_q)
    );

endmodule

//--- tests/wb_bram_checker.sv
`timescale 1ns/1ps
`include "wb_bram_consts.svh"

module wb_bram_checker (
    input logic                    clk,
    input logic                    reset,
    input wb_bram_pkg::wb_req_t    wb_req_i,
    input wb_bram_pkg::wb_rsp_t    wb_rsp_o,
    input wb_bram_pkg::bram_port_t ram_o
);
    import wb_bram_pkg::*;

    int unsigned fail_count = 0; // Failed assertions so far

    // ack cleared by the edge after any reset cycle
    ack_after_reset: assert property (@(posedge clk) reset |=> !wb_rsp_o.ack)
        else
        begin
            fail_count++;
            $error("ack high in the cycle after a reset cycle");
        end

    // Classic ack is a single pulse
    classic_ack_pulse: assert property (@(posedge clk) disable iff (reset)
        (wb_rsp_o.ack && wb_req_i.cyc && (wb_req_i.cti == `WB_CTI_CLASSIC)) |=> !wb_rsp_o.ack)
        else
        begin
            fail_count++;
            $error("classic ack held for more than one cycle");
        end

    ram_we_in_cycle: assert property (@(posedge clk) disable iff (reset)
        ram_o.we |-> wb_req_i.cyc) // Write back must finish inside the bus cycle
        else
        begin
            fail_count++;
            $error("RAM write while cyc is low");
        end

endmodule

//--- tests/wb_bram_tb.sv
`timescale 1ns/1ps
`include "wb_bram_consts.svh"

module wb_bram_tb;
    import wb_bram_pkg::*;

    localparam int MAX_VEC = 64; // Lines the vector table can hold
    localparam int TIMEOUT = 20; // Cycles allowed for one ack

    logic        clk;
    logic        reset;
    wb_req_t     req;
    wb_rsp_t     rsp;
    logic [31:0] vec_mem [0:6*MAX_VEC-1]; // Six fields per line
    bram_word_u  model_mem [0:`WB_RAM_DEPTH-1];
    logic [31:0] lcg_state;
    int          error_count;
    int          check_count;
    int          waited; // Cycles from stb to ack of the last beat
    int          vi;
    bit          timed_out;

    wb_bram_top #(.BURST_EN(1'b1)) u_dut (
        .clk(clk), .reset(reset), .wb_req_i(req), .wb_rsp_o(rsp)
    );

    bind wb_bram_ctrl wb_bram_checker u_checker (
        .clk(clk), .reset(reset), .wb_req_i(wb_req_i), .wb_rsp_o(wb_rsp_o), .ram_o(ram_o)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Selected lanes from the bus, the rest kept
    function automatic bram_word_u merge_lanes(input bram_word_u old_w, input logic [31:0] data,
                                               input logic [3:0] sel);
        bram_word_u res;
        bram_word_u src;
        res      = old_w;
        src.word = data;
        for (int b = 0; b < `WB_SEL_W; b++)
            if (sel[b])
                res.bytes[b] = src.bytes[b];
        return res;
    endfunction

    task automatic wait_ack(input int i);
        waited = 0;
        @(negedge clk);
        while ((rsp.ack !== 1'b1) && !timed_out)
        begin
            if (waited == TIMEOUT)
            begin
                $display("Timeout: no ack for vector %0d within %0d cycles", i, TIMEOUT);
                timed_out = 1'b1;
            end
            else
            begin
                @(negedge clk);
                waited++;
            end
        end
    endtask

    task automatic check_beat(input int i, input int beat);
        int          exp_wait;
        logic [31:0] exp_vec;
        exp_wait = ((beat == 0) || (req.sel != 4'hf)) ? 1 : 0; // Sub-word beats pay for RMW
        exp_vec  = vec_mem[6*i+5];
        check_count++;
        assert (waited == exp_wait)
        else
        begin
            $display("[ERROR] wb_rsp_o.ack delay, vector %0d: got %h expected %h",
                     i, waited, exp_wait);
            error_count++;
        end
        if (req.we)
            model_mem[req.addr] = merge_lanes(model_mem[req.addr], req.dat, req.sel);
        else
        begin
            check_count += 2;
            assert (rsp.dat === model_mem[req.addr].word)
            else
            begin
                $display("[ERROR] wb_rsp_o.dat at %h: got %h model %h",
                         req.addr, rsp.dat, model_mem[req.addr].word);
                error_count++;
            end
            assert (rsp.dat === exp_vec)
            else
            begin
                $display("[ERROR] wb_rsp_o.dat at %h: got %h vector %h",
                         req.addr, rsp.dat, exp_vec);
                error_count++;
            end
        end
    endtask

    // A classic access, or a burst closed by the first line that is not INCR
    task automatic run_transfer(inout int i);
        int beat;
        beat = 0;
        do
        begin
            if (beat != 0)
            begin
                @(posedge clk);
                #1;
            end
            lcg_state = lcg_next(lcg_state);
            req.cyc   = 1'b1;
            req.stb   = 1'b1;
            req.we    = (vec_mem[6*i] == 32'd1);
            req.cti   = vec_mem[6*i+1][`WB_CTI_W-1:0];
            req.sel   = vec_mem[6*i+2][`WB_SEL_W-1:0];
            req.addr  = vec_mem[6*i+3][`WB_ADDR_W-1:0];
            req.dat   = req.we ? vec_mem[6*i+4] : lcg_state; // Filler on reads
            wait_ack(i);
            if (!timed_out)
                check_beat(i, beat);
            beat++;
            i++;
        end
        while ((req.cti == `WB_CTI_INCR) && !timed_out);
    endtask

    // Reserved cycle type, ack expected in the stb cycle itself
    task automatic run_reg_ack(input int i);
        req.cyc  = 1'b1;
        req.stb  = 1'b1;
        req.we   = 1'b0;
        req.cti  = `WB_CTI_REG_ACK;
        req.addr = vec_mem[6*i+3][`WB_ADDR_W-1:0];
        @(negedge clk);
        check_count += 2;
        assert (rsp.ack === 1'b1)
        else
        begin
            $display("[ERROR] wb_rsp_o.ack with stb: got %h expected 1", rsp.ack);
            error_count++;
        end
        @(posedge clk);
        #1 req.stb = 1'b0;
        @(negedge clk);
        assert (rsp.ack === 1'b0)
        else
        begin
            $display("[ERROR] wb_rsp_o.ack after stb: got %h expected 0", rsp.ack);
            error_count++;
        end
    endtask

    task automatic release_bus;
        @(posedge clk);
        #1 req.stb = 1'b0; // cyc held while a merged word is written back
        @(posedge clk);
        #1;
        lcg_state = lcg_next(lcg_state);
        req.cyc   = 1'b0;
        req.we    = 1'b0;
        req.cti   = `WB_CTI_CLASSIC;
        req.dat   = lcg_state;
        @(posedge clk);
        #1;
    endtask

    initial
    begin
        clk         = 1'b0;
        reset       = 1'b1;
        req         = '0;
        lcg_state   = 32'd10724;
        error_count = 0;
        check_count = 0;
        timed_out   = 1'b0;
        $readmemh("tests/wb_bram_vectors.txt", vec_mem);
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        for (int c = 0; c < 10; c++) // Quiet bus after reset
        begin
            @(negedge clk);
            check_count++;
            assert (rsp.ack === 1'b0)
            else
            begin
                $display("[ERROR] wb_rsp_o.ack idle: got %h expected 0", rsp.ack);
                error_count++;
            end
        end
        @(posedge clk);
        #1 vi = 0;
        while ((vi < MAX_VEC) && !timed_out && (vec_mem[6*vi] inside {32'd1, 32'd2, 32'd3}))
        begin
            if (vec_mem[6*vi] == 32'd3)
            begin
                run_reg_ack(vi);
                vi++;
            end
            else
                run_transfer(vi);
            release_bus();
        end
        $display("Checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
                 check_count, error_count, u_dut.u_ctrl.u_checker.fail_count, timed_out);
        if ((error_count == 0) && (u_dut.u_ctrl.u_checker.fail_count == 0) && !timed_out)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- tests/wb_bram_vectors.txt
// op cti sel addr data expect  (all hex, one bus operation per line)
// op 1 write, 2 read, 3 reserved cycle type, 0 end; cti 2 carries the burst on
1 0 f 005 cafe0123 00000000
2 0 f 005 00000000 cafe0123
1 0 f 006 11223344 00000000
1 0 1 006 000000aa 00000000
1 0 6 006 00bbcc00 00000000
1 0 8 006 dd000000 00000000
2 0 f 006 00000000 ddbbccaa
1 2 f 010 a0a0a0a0 00000000
1 2 f 011 b1b1b1b1 00000000
1 2 f 012 c2c2c2c2 00000000
1 7 f 013 d3d3d3d3 00000000
2 2 f 010 00000000 a0a0a0a0
2 2 f 011 00000000 b1b1b1b1
2 2 f 012 00000000 c2c2c2c2
2 7 f 013 00000000 d3d3d3d3
1 2 3 011 00005511 00000000
1 2 3 012 00006622 00000000
1 7 3 013 00007733 00000000
2 2 f 011 00000000 b1b15511
2 2 f 012 00000000 c2c26622
2 7 f 013 00000000 d3d37733
3 4 f 010 00000000 00000000
2 7 f 006 00000000 ddbbccaa
0 0 0 000 00000000 00000000

//--- wb_bram.f
+incdir+common
common/wb_bram_pkg.sv
design/bram_sp.sv
wb_bram_ctrl/wb_burst_bram_ctrl.sv
wb_bram_ctrl/wb_bram_ctrl.sv
design/wb_bram_top.sv
tests/wb_bram_checker.sv
tests/wb_bram_tb.sv

//--- wb_bram_ctrl/wb_bram_ctrl.sv
`timescale 1ns/1ps
`include "wb_bram_consts.svh"

module wb_bram_ctrl #(
    parameter bit BURST_EN = 1'b1 // 1 selects the burst controller
) (
    input  logic                    clk,
    input  logic                    reset,
    input  wb_bram_pkg::wb_req_t    wb_req_i,
    output wb_bram_pkg::wb_rsp_t    wb_rsp_o,
    output wb_bram_pkg::bram_port_t ram_o,
    input  logic [`WB_DATA_W-1:0]   ram_q_i
);
    import wb_bram_pkg::*;

    wb_rsp_t path_rsp;    // Response of whichever path is built
    logic    reg_ack_cyc; // Master registers ack on its side

    assign reg_ack_cyc = (wb_req_i.cti == `WB_CTI_REG_ACK);

    // Ack straight from stb for the reserved cycle type
    assign wb_rsp_o.ack = reg_ack_cyc ? wb_req_i.stb : path_rsp.ack;
    assign wb_rsp_o.dat = path_rsp.dat;

    generate
        if (BURST_EN)
        begin : g_burst
            wb_burst_bram_ctrl u_burst (
                .clk      (clk),
                .reset    (reset),
                .wb_req_i (wb_req_i),
                .rsp_o    (path_rsp),
                .ram_o    (ram_o),
                .ram_q_i  (ram_q_i)
            );
        end
        else
        begin : g_single
            logic ack_q;

            // Plain single cycle access, no byte merge
            assign ram_o.d    = wb_req_i.dat;
            assign ram_o.addr = wb_req_i.addr;
            assign ram_o.we   = wb_req_i.stb & wb_req_i.cyc & wb_req_i.we;

            assign path_rsp.dat = ram_q_i; // RAM latency matches ack delay
            assign path_rsp.ack = ack_q;

            // Ack one cycle after stb, then one idle cycle
            always_ff @(posedge clk)
            begin
                if (reset)
                    ack_q <= 1'b0;
                else
                    ack_q <= ~wb_rsp_o.ack & wb_req_i.stb;
            end
        end
    endgenerate

endmodule

//--- wb_bram_ctrl/wb_burst_bram_ctrl.sv
`timescale 1ns/1ps
`include "wb_bram_consts.svh"

module wb_burst_bram_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  wb_bram_pkg::wb_req_t    wb_req_i,
    output wb_bram_pkg::wb_rsp_t    rsp_o,
    output wb_bram_pkg::bram_port_t ram_o,
    input  logic [`WB_DATA_W-1:0]   ram_q_i
);
    import wb_bram_pkg::*;

    localparam logic [2:0] ST_IDLE  = 3'b000;
    localparam logic [2:0] ST_BURST = 3'b001; // Full word burst, one beat per cycle
    localparam logic [2:0] ST_END   = 3'b010; // Classic access, ack cycle
    localparam logic [2:0] ST_SUBRD = 3'b100; // First sub-word beat, data straight from RAM
    localparam logic [2:0] ST_SUB   = 3'b101; // Later sub-word beats, data from rd_q
    localparam logic [2:0] ST_SUBWR = 3'b110; // Write back of the merged word

    logic [2:0]            state;
    logic [2:0]            state_nxt;
    logic                  ack_q;
    logic                  ack_nxt;
    logic                  req_new;    // Fresh request while idle
    logic                  burst_req;  // Incrementing or reserved cycle type
    logic                  full_word;  // All four lanes selected
    logic                  sub_beat;   // Sub-word ack cycle
    logic                  wr_en;
    logic [`WB_ADDR_W-1:0] burst_addr; // Next word to read ahead
    logic [`WB_ADDR_W-1:0] wr_addr_q;  // Address of the pending merged word
    logic [`WB_DATA_W-1:0] wr_data_q;  // Merged word waiting for write back
    logic [`WB_DATA_W-1:0] rd_q;       // Read ahead word for the next beat
    logic                  last_q;     // Pending beat carried cti END
    logic                  raw_hazard; // Read ahead hit the pending address
    bram_word_u            old_word;
    bram_word_u            new_word;
    bram_word_u            merged;

    assign req_new   = wb_req_i.stb & wb_req_i.cyc & ~ack_q;
    assign burst_req = (wb_req_i.cti == `WB_CTI_INCR) || (wb_req_i.cti == `WB_CTI_REG_ACK);
    assign full_word = &wb_req_i.sel;
    assign sub_beat  = (state == ST_SUBRD) || (state == ST_SUB);

    always_comb
    begin
        state_nxt = state;
        ack_nxt   = 1'b0;
        case (state)
            ST_IDLE:
            begin
                ack_nxt = req_new; // Ack on the very next edge
                if (req_new)
                begin
                    if (!burst_req)
                        state_nxt = ST_END;
                    else if (wb_req_i.we && !full_word)
                        state_nxt = ST_SUBRD; // Needs read-modify-write
                    else
                        state_nxt = ST_BURST;
                end
            end
            ST_BURST:
            begin
                // Stop acking once the END beat is acked
                ack_nxt = wb_req_i.cyc & wb_req_i.stb & (wb_req_i.cti != `WB_CTI_END);
                if ((wb_req_i.cti == `WB_CTI_END) || !wb_req_i.cyc)
                    state_nxt = ST_IDLE;
            end
            ST_END:
                state_nxt = ST_IDLE;
            ST_SUBRD, ST_SUB:
                state_nxt = ST_SUBWR; // RAM port is busy next cycle
            ST_SUBWR:
            begin
                ack_nxt   = ~last_q;
                state_nxt = last_q ? ST_IDLE : ST_SUB;
            end
            default:
                state_nxt = ST_IDLE;
        endcase
    end

    // Byte lane merge, new bytes where selected, RAM bytes elsewhere
    always_comb
    begin
        old_word.word = (state == ST_SUB) ? rd_q : ram_q_i;
        new_word.word = wb_req_i.dat;
        for (int i = 0; i < `WB_SEL_W; i++)
            merged.bytes[i] = wb_req_i.sel[i] ? new_word.bytes[i] : old_word.bytes[i];
    end

    // Full word writes go at once, sub-word ones a cycle after their ack
    assign wr_en = ((state == ST_IDLE) && req_new && burst_req && wb_req_i.we && full_word)
                 || (((state == ST_BURST) || (state == ST_END))
                     && wb_req_i.stb && wb_req_i.cyc && wb_req_i.we)
                 || (state == ST_SUBWR);

    always_comb
    begin
        ram_o.we = wr_en;
        ram_o.d  = (state == ST_SUBWR) ? wr_data_q : merged.word;
        if (state == ST_SUBWR)
            ram_o.addr = wr_addr_q;
        else if ((state == ST_IDLE) || wr_en)
            ram_o.addr = wb_req_i.addr; // First read of any access, or direct write
        else
            ram_o.addr = burst_addr;    // Read ahead
    end

    assign rsp_o.dat = ram_q_i; // Valid with ack, one cycle after the address
    assign rsp_o.ack = ack_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= ST_IDLE;
            ack_q      <= 1'b0;
            burst_addr <= '0;
            last_q     <= 1'b0;
            raw_hazard <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            ack_q <= ack_nxt;
            if (state == ST_IDLE)
                burst_addr <= wb_req_i.addr + 1'b1;
            else if ((state == ST_BURST) || sub_beat)
                burst_addr <= burst_addr + 1'b1;
            if (sub_beat)
            begin
                last_q     <= (wb_req_i.cti == `WB_CTI_END);
                raw_hazard <= (burst_addr == wb_req_i.addr); // Read ahead sees stale word
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (sub_beat)
        begin
            wr_data_q <= merged.word;
            wr_addr_q <= wb_req_i.addr;
        end
        // Keep the read ahead word, or forward the merged one on a hit
        if (state == ST_SUBWR)
            rd_q <= raw_hazard ? wr_data_q : ram_q_i;
    end

endmodule
